// File: design/cmd_gen_pkg.sv
// ##############################
// DDR2 command generator, shared definitions
// ratio fixed at 4, burst length fixed at 8
// field widths are upper bounds and the CSRs narrow them
// ##############################
package cmd_gen_pkg;

    localparam int LOCAL_ADDR_WIDTH = 33;
    localparam int LOCAL_SIZE_WIDTH = 6;

    localparam int MEM_CHIP_BITS = 2;
    localparam int MEM_BA_WIDTH  = 3;
    localparam int MEM_ROW_WIDTH = 16;
    localparam int MEM_COL_WIDTH = 12;

    localparam int CSR_COL_WIDTH  = 4;
    localparam int CSR_ROW_WIDTH  = 5;
    localparam int CSR_BANK_WIDTH = 2;
    localparam int CSR_CS_WIDTH   = 2;

    // wide enough for the sum of all CSR widths
    localparam int CSR_OFF_WIDTH = 6;

    localparam int DWIDTH_RATIO    = 4;
    localparam int BURST_LENGTH    = 8;
    localparam int WORDS_PER_BURST = 2;
    localparam int COL_WORD_SHIFT  = 2;
    localparam int BURST_COL_BITS  = $clog2(BURST_LENGTH);

    // these field bits exist whatever the CSRs say
    localparam int MIN_COL  = 8;
    localparam int MIN_ROW  = 12;
    localparam int MIN_BANK = 2;
    localparam int MIN_CS   = 1;

    typedef logic [MEM_CHIP_BITS-1:0]    chip_addr_t;
    typedef logic [MEM_BA_WIDTH-1:0]     bank_addr_t;
    typedef logic [MEM_ROW_WIDTH-1:0]    row_addr_t;
    typedef logic [MEM_COL_WIDTH-1:0]    col_addr_t;
    typedef logic [LOCAL_SIZE_WIDTH-1:0] local_size_t;

    // codes 2 and 3 are treated like code 0
    typedef enum logic [1:0] {
        ORDER_CHIP_ROW_BANK_COL = 2'd0,
        ORDER_CHIP_BANK_ROW_COL = 2'd1
    } addr_order_e;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        REGISTERED = 2'd1,
        GENERATING = 2'd2
    } split_state_e;

endpackage

// File: design/addr_decoder.sv
`timescale 1ns/10ps

// ##############################
// CSR widths are registered, so they must be stable
// one clock before the first request
// the field split itself is combinational
// ##############################
module addr_decoder
    import cmd_gen_pkg::*;
(
    input  logic                        ctl_clk,
    input  logic                        ctl_reset_n,
    input  logic [LOCAL_ADDR_WIDTH-1:0] local_addr,
    input  logic [1:0]                  addr_order,
    input  logic [CSR_COL_WIDTH-1:0]    col_width_csr,
    input  logic [CSR_ROW_WIDTH-1:0]    row_width_csr,
    input  logic [CSR_BANK_WIDTH-1:0]   bank_width_csr,
    input  logic [CSR_CS_WIDTH-1:0]     cs_width_csr,
    output chip_addr_t                  dec_cs,
    output bank_addr_t                  dec_bank,
    output row_addr_t                   dec_row,
    output col_addr_t                   dec_col
);

    logic [CSR_OFF_WIDTH-1:0]    col_bits;
    logic [CSR_OFF_WIDTH-1:0]    col_off;
    logic [CSR_OFF_WIDTH-1:0]    col_row_off;
    logic [CSR_OFF_WIDTH-1:0]    col_bank_off;
    logic [CSR_OFF_WIDTH-1:0]    col_row_bank_off;
    logic                        row_above_col;
    logic [LOCAL_ADDR_WIDTH-1:0] row_src;
    logic [LOCAL_ADDR_WIDTH-1:0] bank_src;
    logic [LOCAL_ADDR_WIDTH-1:0] cs_src;
    col_addr_t                   col_words;

    // the column counts memory beats, the local address counts words
    assign col_bits = CSR_OFF_WIDTH'(col_width_csr) - CSR_OFF_WIDTH'(DWIDTH_RATIO / 2);

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            col_off          <= '0;
            col_row_off      <= '0;
            col_bank_off     <= '0;
            col_row_bank_off <= '0;
        end
        else
        begin
            col_off          <= col_bits;
            col_row_off      <= col_bits + CSR_OFF_WIDTH'(row_width_csr);
            col_bank_off     <= col_bits + CSR_OFF_WIDTH'(bank_width_csr);
            col_row_bank_off <= col_bits + CSR_OFF_WIDTH'(row_width_csr)
                                + CSR_OFF_WIDTH'(bank_width_csr);
        end
    end

    assign row_above_col = (addr_order == ORDER_CHIP_BANK_ROW_COL);

    assign row_src  = local_addr >> (row_above_col ? col_off : col_bank_off);
    assign bank_src = local_addr >> (row_above_col ? col_row_off : col_off);
    assign cs_src   = local_addr >> col_row_bank_off;

    always_comb
    begin
        for (int n = 0; n < MEM_COL_WIDTH; n++)
        begin
            if (n < MIN_COL - COL_WORD_SHIFT || n < col_off)
                col_words[n] = local_addr[n];
            else
                col_words[n] = 1'b0;
        end
    end

    assign dec_col = col_words << COL_WORD_SHIFT;

    always_comb
    begin
        for (int j = 0; j < MEM_ROW_WIDTH; j++)
        begin
            if (j < MIN_ROW || j < row_width_csr)
                dec_row[j] = row_src[j];
            else
                dec_row[j] = 1'b0;
        end
    end

    always_comb
    begin
        for (int k = 0; k < MEM_BA_WIDTH; k++)
        begin
            if (k < MIN_BANK || k < bank_width_csr)
                dec_bank[k] = bank_src[k];
            else
                dec_bank[k] = 1'b0;
        end
    end

    // a single-chip setup reports chip 0 whatever the address
    always_comb
    begin
        for (int m = 0; m < MEM_CHIP_BITS; m++)
        begin
            if (cs_width_csr != '0 && (m < MIN_CS || m < cs_width_csr))
                dec_cs[m] = cs_src[m];
            else
                dec_cs[m] = 1'b0;
        end
    end

endmodule

// File: design/burst_tracker.sv
`timescale 1ns/10ps

// ##############################
// write beats must arrive back to back after write_first
// a generated write lost to ready_in low is not retried
// ##############################
module burst_tracker
    import cmd_gen_pkg::*;
(
    input  logic        ctl_clk,
    input  logic        ctl_reset_n,
    input  logic        local_read_req,
    input  logic        write_first,
    input  logic        write_beat,
    input  local_size_t local_size,
    input  logic        local_autopch_req,
    input  logic        unaligned,
    input  logic        ready_in,
    output logic        ready_out,
    output logic        read_req,
    output logic        write_req,
    output logic [1:0]  size,
    output logic        autopch_req,
    output logic        load,
    output logic        step,
    output logic        gen_active
);

    split_state_e              state;
    logic                      split_req;
    logic                      buf_read;
    logic                      buf_autopch;
    logic [LOCAL_SIZE_WIDTH:0] words_left;
    logic                      pass_write;
    logic                      gen_fire;
    logic                      gen_last;

    assign ready_out  = ready_in & (state == IDLE);
    assign load       = ready_out & (local_read_req | write_first);
    assign split_req  = (local_size > WORDS_PER_BURST) | ((local_size > 1) & unaligned);
    assign gen_active = (state == GENERATING);
    assign gen_last   = (words_left <= 2 * WORDS_PER_BURST);

    // a generated write waits until both words of its burst have arrived
    assign gen_fire = gen_active & ready_in & (buf_read | (write_beat & pass_write));

    // the REGISTERED cycle moves the buffered address past the first burst
    assign step = gen_fire | (state == REGISTERED);

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:
                    if (load && split_req)
                        state <= REGISTERED;
                REGISTERED:
                    state <= GENERATING;
                GENERATING:
                    if (gen_fire && gen_last)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            buf_read    <= 1'b0;
            buf_autopch <= 1'b0;
            words_left  <= '0;
        end
        else if (load)
        begin
            buf_read    <= local_read_req;
            buf_autopch <= local_autopch_req;
            // an unaligned start wastes the first word slot of its burst
            words_left  <= {1'b0, local_size} + {{LOCAL_SIZE_WIDTH{1'b0}}, unaligned};
        end
        else if (gen_fire)
            words_left <= words_left - (LOCAL_SIZE_WIDTH + 1)'(WORDS_PER_BURST);
    end

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
            pass_write <= 1'b0;
        else if (load && split_req)
            pass_write <= unaligned;
        else if (write_beat && state != REGISTERED)
            pass_write <= ~pass_write;
    end

    always_comb
    begin
        if (gen_active)
        begin
            read_req    = buf_read & ready_in;
            write_req   = ~buf_read & write_beat & ready_in & pass_write;
            autopch_req = buf_autopch;
            size        = (words_left > WORDS_PER_BURST + 1) ? 2'd2 : 2'd1;
        end
        else
        begin
            read_req    = local_read_req;
            write_req   = write_first;
            autopch_req = local_autopch_req;
            size        = (local_size > 1 && !unaligned) ? 2'd2 : 2'd1;
        end
    end

endmodule

// File: design/addr_stepper.sv
`timescale 1ns/10ps

// ##############################
// steps one burst per advance
// every field wraps at its CSR width
// ##############################
module addr_stepper
    import cmd_gen_pkg::*;
(
    input  logic                      ctl_clk,
    input  logic                      ctl_reset_n,
    input  logic                      load,
    input  logic                      step,
    input  logic                      gen_active,
    input  logic [1:0]                addr_order,
    input  chip_addr_t                dec_cs,
    input  bank_addr_t                dec_bank,
    input  row_addr_t                 dec_row,
    input  col_addr_t                 dec_col,
    input  logic [CSR_COL_WIDTH-1:0]  col_width_csr,
    input  logic [CSR_ROW_WIDTH-1:0]  row_width_csr,
    input  logic [CSR_BANK_WIDTH-1:0] bank_width_csr,
    input  logic [CSR_CS_WIDTH-1:0]   cs_width_csr,
    output chip_addr_t                cs_addr,
    output bank_addr_t                bank_addr,
    output row_addr_t                 row_addr,
    output col_addr_t                 col_addr
);

    chip_addr_t max_cs;
    bank_addr_t max_bank;
    row_addr_t  max_row;
    col_addr_t  max_col;
    chip_addr_t buf_cs;
    bank_addr_t buf_bank;
    row_addr_t  buf_row;
    col_addr_t  buf_col;
    logic       row_above_col;
    logic       col_wrap;
    logic       row_wrap;
    logic       bank_wrap;
    logic       cs_wrap;
    logic       row_inc;
    logic       bank_inc;
    logic       cs_inc;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            max_cs   <= '0;
            max_bank <= '0;
            max_row  <= '0;
            max_col  <= '0;
        end
        else
        begin
            max_cs   <= chip_addr_t'((1 << cs_width_csr) - 1);
            max_bank <= bank_addr_t'((1 << bank_width_csr) - 1);
            max_row  <= row_addr_t'((1 << row_width_csr) - 1);
            max_col  <= col_addr_t'((1 << col_width_csr) - 1);
        end
    end

    assign row_above_col = (addr_order == ORDER_CHIP_BANK_ROW_COL);

    assign col_wrap  = (buf_col[MEM_COL_WIDTH-1:BURST_COL_BITS]
                        == max_col[MEM_COL_WIDTH-1:BURST_COL_BITS]);
    assign row_wrap  = (buf_row == max_row);
    assign bank_wrap = (buf_bank == max_bank);
    assign cs_wrap   = (buf_cs == max_cs);

    // the field right above the column takes the carry first
    assign row_inc  = col_wrap & (row_above_col | bank_wrap);
    assign bank_inc = col_wrap & (~row_above_col | row_wrap);
    assign cs_inc   = col_wrap & row_wrap & bank_wrap;

    always_ff @(posedge ctl_clk)
    begin
        if (load)
        begin
            buf_cs   <= dec_cs;
            buf_bank <= dec_bank;
            buf_row  <= dec_row;
            buf_col  <= dec_col;
        end
        else if (step)
        begin
            if (col_wrap)
                buf_col[MEM_COL_WIDTH-1:BURST_COL_BITS] <= '0;
            else
                buf_col <= buf_col + col_addr_t'(BURST_LENGTH);
            if (row_inc)
                buf_row <= row_wrap ? '0 : buf_row + 1'b1;
            if (bank_inc)
                buf_bank <= bank_wrap ? '0 : buf_bank + 1'b1;
            if (cs_inc)
                buf_cs <= cs_wrap ? '0 : buf_cs + 1'b1;
        end
    end

    assign cs_addr   = gen_active ? buf_cs : dec_cs;
    assign bank_addr = gen_active ? buf_bank : dec_bank;
    assign row_addr  = gen_active ? buf_row : dec_row;
    // generated bursts always start on a burst boundary
    assign col_addr  = gen_active
                       ? {buf_col[MEM_COL_WIDTH-1:BURST_COL_BITS], {BURST_COL_BITS{1'b0}}}
                       : dec_col;

endmodule

// File: design/cmd_gen_top.sv
`timescale 1ns/10ps

// ##############################
// DDR2 command generator top
// ready_out stays low while a split request is issued
// ##############################
module cmd_gen_top
    import cmd_gen_pkg::*;
(
    input  logic                        ctl_clk,
    input  logic                        ctl_reset_n,
    input  logic                        local_read_req,
    input  logic                        write_first,
    input  logic                        write_beat,
    input  local_size_t                 local_size,
    input  logic                        local_autopch_req,
    input  logic [LOCAL_ADDR_WIDTH-1:0] local_addr,
    input  logic [1:0]                  addr_order,
    input  logic [CSR_COL_WIDTH-1:0]    col_width_csr,
    input  logic [CSR_ROW_WIDTH-1:0]    row_width_csr,
    input  logic [CSR_BANK_WIDTH-1:0]   bank_width_csr,
    input  logic [CSR_CS_WIDTH-1:0]     cs_width_csr,
    input  logic                        ready_in,
    output logic                        ready_out,
    output logic                        read_req,
    output logic                        write_req,
    output logic [1:0]                  size,
    output logic                        autopch_req,
    output chip_addr_t                  cs_addr,
    output bank_addr_t                  bank_addr,
    output row_addr_t                   row_addr,
    output col_addr_t                   col_addr
);

    chip_addr_t dec_cs;
    bank_addr_t dec_bank;
    row_addr_t  dec_row;
    col_addr_t  dec_col;
    logic       load;
    logic       step;
    logic       gen_active;

    addr_decoder u_decoder (
        .ctl_clk        (ctl_clk),
        .ctl_reset_n    (ctl_reset_n),
        .local_addr     (local_addr),
        .addr_order     (addr_order),
        .col_width_csr  (col_width_csr),
        .row_width_csr  (row_width_csr),
        .bank_width_csr (bank_width_csr),
        .cs_width_csr   (cs_width_csr),
        .dec_cs         (dec_cs),
        .dec_bank       (dec_bank),
        .dec_row        (dec_row),
        .dec_col        (dec_col)
    );

    // the word-in-burst bit of the column marks an unaligned start
    burst_tracker u_tracker (
        .ctl_clk           (ctl_clk),
        .ctl_reset_n       (ctl_reset_n),
        .local_read_req    (local_read_req),
        .write_first       (write_first),
        .write_beat        (write_beat),
        .local_size        (local_size),
        .local_autopch_req (local_autopch_req),
        .unaligned         (dec_col[COL_WORD_SHIFT]),
        .ready_in          (ready_in),
        .ready_out         (ready_out),
        .read_req          (read_req),
        .write_req         (write_req),
        .size              (size),
        .autopch_req       (autopch_req),
        .load              (load),
        .step              (step),
        .gen_active        (gen_active)
    );

    addr_stepper u_stepper (
        .ctl_clk        (ctl_clk),
        .ctl_reset_n    (ctl_reset_n),
        .load           (load),
        .step           (step),
        .gen_active     (gen_active),
        .addr_order     (addr_order),
        .dec_cs         (dec_cs),
        .dec_bank       (dec_bank),
        .dec_row        (dec_row),
        .dec_col        (dec_col),
        .col_width_csr  (col_width_csr),
        .row_width_csr  (row_width_csr),
        .bank_width_csr (bank_width_csr),
        .cs_width_csr   (cs_width_csr),
        .cs_addr        (cs_addr),
        .bank_addr      (bank_addr),
        .row_addr       (row_addr),
        .col_addr       (col_addr)
    );

endmodule

// File: tests/tb_cmd_gen_tests.svh
// ##############################
// directed tests, included into the testbench top
// each test starts and ends on a falling clock edge
// ##############################

task automatic test_after_reset();
    logic [63:0] bits;
    repeat (12)
    begin
        draw_bits(1, bits);
        ready_in = bits[0];
        @(posedge ctl_clk);
        check_value("ready_out", ready_out, ready_in);
        @(negedge ctl_clk);
    end
    ready_in = 1'b1;
endtask

task automatic test_single_reads();
    logic [63:0] bits;
    logic [63:0] ap;
    set_csr(1, 10, 14, 3, 1);
    for (int i = 0; i < 4; i++)
    begin
        draw_bits(LOCAL_ADDR_WIDTH, bits);
        bits[0] = 1'b0;
        draw_bits(1, ap);
        issue_request(1'b0, bits, (i % 2) + 1, ap[0]);
        finish_series();
    end
endtask

task automatic test_long_read();
    logic [63:0] bits;
    set_csr(0, 8, 13, 3, 2);
    draw_bits(LOCAL_ADDR_WIDTH, bits);
    // column burst 28 of 31 and bank 6, so the series wraps into the bank
    bits[8:0] = 9'b110_111000;
    issue_request(1'b0, bits, 12, 1'b0);
    finish_series();
endtask

task automatic test_unaligned_read();
    logic [63:0] bits;
    int          total;
    set_csr(1, 9, 12, 2, 0);
    draw_bits(LOCAL_ADDR_WIDTH, bits);
    bits[0] = 1'b1;
    seen_sizes.delete();
    issue_request(1'b0, bits, 2, 1'b1);
    finish_series();
    total = 0;
    foreach (seen_sizes[k])
        total = total + seen_sizes[k];
    check_value("first size", seen_sizes[0], 1);
    check_value("size total", total, 2);
endtask

task automatic test_back_pressure();
    logic [63:0] bits;
    set_csr(1, 11, 15, 3, 2);
    draw_bits(LOCAL_ADDR_WIDTH, bits);
    bits[0] = 1'b0;
    issue_request(1'b0, bits, 10, 1'b0);
    // let one generated command out before the stall
    repeat (2) @(negedge ctl_clk);
    ready_in = 1'b0;
    repeat (4)
    begin
        @(posedge ctl_clk);
        check_value("ready_out", ready_out, 1'b0);
        check_value("read_req", read_req, 1'b0);
    end
    @(negedge ctl_clk);
    ready_in = 1'b1;
    finish_series();
endtask

task automatic test_split_write();
    logic [63:0] bits;
    set_csr(0, 10, 16, 3, 1);
    draw_bits(LOCAL_ADDR_WIDTH, bits);
    bits[0] = 1'b0;
    issue_request(1'b1, bits, 8, 1'b1);
    finish_series();
endtask

// File: tests/tb_cmd_gen.sv
`timescale 1ns/10ps

// ##############################
// directed testbench for the DDR2 command generator
// CSR widths are kept at or above the minimum field widths
// the run stops at the first error
// ##############################
module tb_cmd_gen
    import cmd_gen_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int TEST_COUNT   = 6;
    localparam int WAIT_LIMIT   = 100;

    typedef struct packed {
        logic       wr;
        logic       ap;
        logic [1:0] sz;
        chip_addr_t cs;
        bank_addr_t ba;
        row_addr_t  row;
        col_addr_t  col;
    } cmd_t;

    logic                        ctl_clk;
    logic                        ctl_reset_n;
    logic                        local_read_req;
    logic                        write_first;
    logic                        write_beat;
    local_size_t                 local_size;
    logic                        local_autopch_req;
    logic [LOCAL_ADDR_WIDTH-1:0] local_addr;
    logic [1:0]                  addr_order;
    logic [CSR_COL_WIDTH-1:0]    col_width_csr;
    logic [CSR_ROW_WIDTH-1:0]    row_width_csr;
    logic [CSR_BANK_WIDTH-1:0]   bank_width_csr;
    logic [CSR_CS_WIDTH-1:0]     cs_width_csr;
    logic                        ready_in;
    logic                        ready_out;
    logic                        read_req;
    logic                        write_req;
    logic [1:0]                  size;
    logic                        autopch_req;
    chip_addr_t                  cs_addr;
    bank_addr_t                  bank_addr;
    row_addr_t                   row_addr;
    col_addr_t                   col_addr;

    cmd_t        exp_q[$];
    cmd_t        mon_cmd;
    int          seen_sizes[$];
    logic [31:0] lfsr_state;

    cmd_gen_top dut0 (
        .ctl_clk           (ctl_clk),
        .ctl_reset_n       (ctl_reset_n),
        .local_read_req    (local_read_req),
        .write_first       (write_first),
        .write_beat        (write_beat),
        .local_size        (local_size),
        .local_autopch_req (local_autopch_req),
        .local_addr        (local_addr),
        .addr_order        (addr_order),
        .col_width_csr     (col_width_csr),
        .row_width_csr     (row_width_csr),
        .bank_width_csr    (bank_width_csr),
        .cs_width_csr      (cs_width_csr),
        .ready_in          (ready_in),
        .ready_out         (ready_out),
        .read_req          (read_req),
        .write_req         (write_req),
        .size              (size),
        .autopch_req       (autopch_req),
        .cs_addr           (cs_addr),
        .bank_addr         (bank_addr),
        .row_addr          (row_addr),
        .col_addr          (col_addr)
    );

    initial
    begin
        ctl_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ctl_clk = ~ctl_clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
            report_failure($sformatf("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h",
                                     $time, name, got, exp));
    endtask

    // Galois form, taps for x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    task automatic draw_bits(input int count, output logic [63:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            bits = {bits[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic int field_bits(input logic [63:0] a, input int lsb, input int width);
        field_bits = int'((a >> lsb) & ((64'd1 << width) - 64'd1));
    endfunction

    task automatic decode_addr(input logic [63:0] a, output int cs, output int ba,
                               output int row, output int col);
        int cb;
        int row_off;
        int bank_off;
        cb = int'(col_width_csr) - 2;
        if (addr_order == 2'd1)
        begin
            row_off  = cb;
            bank_off = cb + int'(row_width_csr);
        end
        else
        begin
            bank_off = cb;
            row_off  = cb + int'(bank_width_csr);
        end
        col = field_bits(a, 0, cb) << 2;
        row = field_bits(a, row_off, row_width_csr);
        ba  = field_bits(a, bank_off, bank_width_csr);
        cs  = field_bits(a, cb + int'(row_width_csr) + int'(bank_width_csr), cs_width_csr);
    endtask

    task automatic bump_field(inout int value, input int width, inout logic carry);
        if (carry)
        begin
            if (value == (1 << width) - 1)
                value = 0;
            else
            begin
                value = value + 1;
                carry = 1'b0;
            end
        end
    endtask

    // one burst up, carrying into the field that sits above the column
    task automatic advance_fields(inout int cs, inout int ba, inout int row, inout int col);
        logic carry;
        carry = 1'b0;
        if ((col >> 3) == (((1 << col_width_csr) - 1) >> 3))
        begin
            col   = 0;
            carry = 1'b1;
        end
        else
            col = ((col >> 3) + 1) << 3;
        if (addr_order == 2'd1)
        begin
            bump_field(row, row_width_csr, carry);
            bump_field(ba, bank_width_csr, carry);
        end
        else
        begin
            bump_field(ba, bank_width_csr, carry);
            bump_field(row, row_width_csr, carry);
        end
        bump_field(cs, cs_width_csr, carry);
    endtask

    task automatic push_cmd(input logic wr, input logic ap, input int sz, input int cs,
                            input int ba, input int row, input int col);
        cmd_t c;
        c.wr  = wr;
        c.ap  = ap;
        c.sz  = 2'(sz);
        c.cs  = chip_addr_t'(cs);
        c.ba  = bank_addr_t'(ba);
        c.row = row_addr_t'(row);
        c.col = col_addr_t'(col);
        exp_q.push_back(c);
    endtask

    task automatic build_expected(input logic is_write, input logic ap,
                                  input logic [63:0] addr, input int req_size);
        int   cs;
        int   ba;
        int   row;
        int   col;
        int   rem;
        logic unaligned;
        decode_addr(addr, cs, ba, row, col);
        unaligned = addr[0];
        push_cmd(is_write, ap, (req_size > 1 && !unaligned) ? 2 : 1, cs, ba, row, col);
        if (req_size > 2 || (req_size > 1 && unaligned))
        begin
            // an unaligned start leaves the first word slot of the first burst empty
            rem = req_size + int'(unaligned) - 2;
            while (rem > 0)
            begin
                advance_fields(cs, ba, row, col);
                push_cmd(is_write, ap, (rem > 1) ? 2 : 1, cs, ba, row, col);
                rem = rem - 2;
            end
        end
    endtask

    always @(posedge ctl_clk)
    begin
        if (ctl_reset_n === 1'b1 && (read_req === 1'b1 || write_req === 1'b1))
        begin
            if (exp_q.size() == 0)
                report_failure($sformatf("unexpected command at %0t ns", $time));
            else
            begin
                mon_cmd = exp_q.pop_front();
                check_value("write_req", write_req, mon_cmd.wr);
                check_value("read_req", read_req, !mon_cmd.wr);
                check_value("autopch_req", autopch_req, mon_cmd.ap);
                check_value("size", size, mon_cmd.sz);
                check_value("cs_addr", cs_addr, mon_cmd.cs);
                check_value("bank_addr", bank_addr, mon_cmd.ba);
                check_value("row_addr", row_addr, mon_cmd.row);
                check_value("col_addr", col_addr, mon_cmd.col);
                seen_sizes.push_back(int'(size));
            end
        end
    end

    task automatic wait_ready_out();
        int n;
        n = 0;
        while (ready_out !== 1'b1)
        begin
            @(negedge ctl_clk);
            n++;
            if (n > WAIT_LIMIT)
                report_failure("ready_out did not return high in time");
        end
    endtask

    task automatic wait_commands_done();
        int n;
        n = 0;
        while (exp_q.size() != 0)
        begin
            @(negedge ctl_clk);
            n++;
            if (n > WAIT_LIMIT)
                report_failure($sformatf("%0d expected commands never appeared",
                                         exp_q.size()));
        end
    endtask

    task automatic set_csr(input int order, input int colw, input int roww,
                           input int bankw, input int csw);
        addr_order     = 2'(order);
        col_width_csr  = CSR_COL_WIDTH'(colw);
        row_width_csr  = CSR_ROW_WIDTH'(roww);
        bank_width_csr = CSR_BANK_WIDTH'(bankw);
        cs_width_csr   = CSR_CS_WIDTH'(csw);
        repeat (2) @(negedge ctl_clk);
    endtask

    task automatic issue_request(input logic is_write, input logic [63:0] addr,
                                 input int req_size, input logic ap);
        wait_ready_out();
        build_expected(is_write, ap, addr, req_size);
        local_addr        = addr[LOCAL_ADDR_WIDTH-1:0];
        local_size        = local_size_t'(req_size);
        local_autopch_req = ap;
        local_read_req    = !is_write;
        write_first       = is_write;
        write_beat        = is_write;
        @(negedge ctl_clk);
        local_read_req = 1'b0;
        write_first    = 1'b0;
        // write data keeps arriving one beat per clock until the series ends
        if (is_write)
        begin
            wait_commands_done();
            write_beat = 1'b0;
        end
    endtask

    // the last command of a series hands ready_out back on the next clock
    task automatic finish_series();
        wait_commands_done();
        check_value("ready_out", ready_out, 1'b1);
    endtask

    `include "tb_cmd_gen_tests.svh"

    initial
    begin
        ctl_reset_n       = 1'b0;
        local_read_req    = 1'b0;
        write_first       = 1'b0;
        write_beat        = 1'b0;
        local_size        = '0;
        local_autopch_req = 1'b0;
        local_addr        = '0;
        addr_order        = 2'd0;
        col_width_csr     = CSR_COL_WIDTH'(10);
        row_width_csr     = CSR_ROW_WIDTH'(14);
        bank_width_csr    = CSR_BANK_WIDTH'(3);
        cs_width_csr      = CSR_CS_WIDTH'(1);
        ready_in          = 1'b1;
        lfsr_state        = 32'd66182;
        repeat (RESET_CYCLES) @(posedge ctl_clk);
        @(negedge ctl_clk);
        ctl_reset_n = 1'b1;
        test_after_reset();
        test_single_reads();
        test_long_read();
        test_unaligned_read();
        test_back_pressure();
        test_split_write();
        repeat (4) @(negedge ctl_clk);
        if (exp_q.size() == 0)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
            report_failure("expected commands were left over at the end of the run");
    end

    initial
    begin
        #((RESET_CYCLES + TEST_COUNT * 200) * CLK_PERIOD);
        report_failure("watchdog expired, the tests did not finish in time");
    end

endmodule

// File: compile.f
+incdir+tests
design/cmd_gen_pkg.sv
design/addr_decoder.sv
design/burst_tracker.sv
design/addr_stepper.sv
design/cmd_gen_top.sv
tests/tb_cmd_gen.sv

// File: Bender.yml
package:
  name: cmd_gen

sources:
  - design/cmd_gen_pkg.sv
  - design/addr_decoder.sv
  - design/burst_tracker.sv
  - design/addr_stepper.sv
  - design/cmd_gen_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_cmd_gen.sv
